// File: common/rvPkg.sv
package rvPkg;

    // datapath and address width
    localparam int XLEN       = 32;
    // register index width, 32 architectural registers
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;
    // a0 holds the visible result
    localparam int REG_A0     = 10;

    // memory depths in words
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 for arithmetic and logic ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // instr[30] tells sub from add in R-type
    localparam int F7_SUB_BIT = 30;

    // alu operation select
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b101
    } aluOpT;

    // immediate format
    typedef enum logic [1:0] {
        IMM_I = 2'b00,
        IMM_S = 2'b01,
        IMM_B = 2'b10
    } immSrcT;

    // writeback source
    typedef enum logic {
        RES_ALU = 1'b0,
        RES_MEM = 1'b1
    } resultSrcT;

endpackage

// File: fetch/pcUnit.sv
module pcUnit import rvPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    input  logic            pcSrc,
    input  logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] pc
);

    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] pcNext;

    // sequential fall-through
    assign pcPlus4  = pc + XLEN'(4);
    // branch target, imm already carries the zero lsb
    assign pcTarget = pc + imm;
    // taken branch wins
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // branch offsets are even and the program is word aligned,
    // so a misaligned pc means a bad immediate or a bad program
    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// File: fetch/instrMem.sv
module instrMem import rvPkg::*; (
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] instr
);

    localparam int IDX_W = $clog2(IMEM_WORDS);

    logic [XLEN-1:0] rom [IMEM_WORDS];
    logic [IDX_W-1:0] wordIdx;

    // program image, one hex word per line
    initial begin
        $readmemh("program.hex", rom);
    end

    // byte address to word index, low two bits dropped
    assign wordIdx = pc[IDX_W+1:2];

    // asynchronous read
    assign instr = rom[wordIdx];

endmodule

// File: decode/controlUnit.sv
module controlUnit import rvPkg::*; (
    input  logic [XLEN-1:0] instr,
    input  logic            eq,
    output logic            regWrite,
    output logic            memWrite,
    output logic            aluSrc,
    output logic            pcSrc,
    output aluOpT           aluOp,
    output immSrcT          immSrc,
    output resultSrcT       resultSrc
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       subBit;
    logic       isBranch;

    // instruction fields
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign subBit = instr[F7_SUB_BIT];

    // main decoder
    always_comb begin
        // safe defaults, unknown opcode does nothing
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        aluSrc    = 1'b0;
        resultSrc = RES_ALU;
        immSrc    = IMM_I;
        isBranch  = 1'b0;
        unique case (opcode)
            OP_RTYPE: begin
                regWrite = 1'b1;
            end
            OP_ITYPE: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_MEM;
            end
            OP_STORE: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = IMM_S;
            end
            OP_BRANCH: begin
                immSrc   = IMM_B;
                isBranch = 1'b1;
            end
            default: ;
        endcase
    end

    // alu decoder
    always_comb begin
        aluOp = ALU_ADD;
        if (isBranch) begin
            // compare by subtraction, eq comes from the alu
            aluOp = ALU_SUB;
        end else if (opcode == OP_RTYPE || opcode == OP_ITYPE) begin
            case (funct3)
                // sub only exists in R-type, addi ignores bit 30
                F3_ADD:  aluOp = (opcode == OP_RTYPE && subBit) ? ALU_SUB : ALU_ADD;
                F3_SLT:  aluOp = ALU_SLT;
                F3_OR:   aluOp = ALU_OR;
                F3_AND:  aluOp = ALU_AND;
                default: aluOp = ALU_ADD;
            endcase
        end
    end

    // branch decision
    assign pcSrc = isBranch && ((funct3 == F3_BEQ && eq) || (funct3 == F3_BNE && !eq));

endmodule

// File: decode/immExtend.sv
module immExtend import rvPkg::*; (
    input  logic [XLEN-1:0] instr,
    input  immSrcT          immSrc,
    output logic [XLEN-1:0] imm
);

    logic sign;

    // sign bit sits at instr[31] in every format
    assign sign = instr[31];

    always_comb begin
        case (immSrc)
            // addi, lw: imm[11:0] in one field
            IMM_I: begin
                imm = {{(XLEN-12){sign}}, instr[31:20]};
            end
            // sw: split around rd slot
            IMM_S: begin
                imm = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            // beq/bne: scrambled bits, lsb always zero
            IMM_B: begin
                imm = {{(XLEN-13){sign}}, sign, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: execute/registerFile.sv
module registerFile import rvPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  regWrite,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [XLEN-1:0]       writeData,
    output logic [XLEN-1:0]       rd1,
    output logic [XLEN-1:0]       rd2,
    output logic [XLEN-1:0]       a0
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // write port, x0 never written so it stays at its reset zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != '0) begin
            regs[rd] <= writeData;
        end
    end

    // two asynchronous read ports
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // result tap
    assign a0 = regs[REG_A0];

    // x0 reads zero through reset and every later write
    x0Zero: assert property (@(posedge clk) disable iff (!arstN)
        (rs1 == '0 |-> rd1 == '0) and (rs2 == '0 |-> rd2 == '0))
        else $error("x0 read nonzero");

endmodule

// File: execute/alu.sv
module alu import rvPkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  aluOpT           aluOp,
    output logic [XLEN-1:0] result,
    output logic            eq
);

    logic lessThan;

    // signed compare for slt and slti
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // zero-extended flag
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lessThan};
            default: result = '0;
        endcase
    end

    // branch compare flag, independent of aluOp
    assign eq = (a == b);

endmodule

// File: rtl/dataMem.sv
module dataMem import rvPkg::*; (
    input  logic            clk,
    input  logic            memWrite,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] writeData,
    output logic [XLEN-1:0] readData
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]  ram [DMEM_WORDS];
    logic [IDX_W-1:0] wordIdx;

    // word index, upper address bits wrap
    assign wordIdx = addr[IDX_W+1:2];

    // store lands on the edge that retires sw
    always_ff @(posedge clk) begin
        if (memWrite) begin
            ram[wordIdx] <= writeData;
        end
    end

    // lw sees the array in the same cycle
    assign readData = ram[wordIdx];

    // only whole-word stores, low bits come from rs1 + imm
    storeAligned: assert property (@(posedge clk) memWrite |-> addr[1:0] == 2'b00)
        else $error("misaligned store to %h", addr);

endmodule

// File: rtl/rvCore.sv
module rvCore import rvPkg::*; (
    input  logic            clk,
    input  logic            arstN,
    output logic [XLEN-1:0] a0
);

    // fetch
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;

    // decode
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  regWrite;
    logic                  memWrite;
    logic                  aluSrc;
    logic                  pcSrc;
    aluOpT                 aluOp;
    immSrcT                immSrc;
    resultSrcT             resultSrc;
    logic [XLEN-1:0]       imm;

    // execute and memory
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluOut;
    logic            eq;
    logic [XLEN-1:0] readData;
    logic [XLEN-1:0] writeData;

    // register fields
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    pcUnit i_pcUnit (
        .clk   (clk),
        .arstN (arstN),
        .pcSrc (pcSrc),
        .imm   (imm),
        .pc    (pc)
    );

    instrMem i_instrMem (
        .pc    (pc),
        .instr (instr)
    );

    controlUnit i_controlUnit (
        .instr     (instr),
        .eq        (eq),
        .regWrite  (regWrite),
        .memWrite  (memWrite),
        .aluSrc    (aluSrc),
        .pcSrc     (pcSrc),
        .aluOp     (aluOp),
        .immSrc    (immSrc),
        .resultSrc (resultSrc)
    );

    immExtend i_immExtend (
        .instr  (instr),
        .immSrc (immSrc),
        .imm    (imm)
    );

    registerFile i_registerFile (
        .clk       (clk),
        .arstN     (arstN),
        .regWrite  (regWrite),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .writeData (writeData),
        .rd1       (rd1),
        .rd2       (rd2),
        .a0        (a0)
    );

    // second operand, register or immediate
    assign aluB = aluSrc ? imm : rd2;

    alu i_alu (
        .a      (rd1),
        .b      (aluB),
        .aluOp  (aluOp),
        .result (aluOut),
        .eq     (eq)
    );

    // rd2 is the store data
    dataMem i_dataMem (
        .clk       (clk),
        .memWrite  (memWrite),
        .addr      (aluOut),
        .writeData (rd2),
        .readData  (readData)
    );

    // writeback select
    assign writeData = (resultSrc == RES_MEM) ? readData : aluOut;

endmodule

// File: test/tbRvCore.sv
module tbRvCore import rvPkg::*; ();

    // run limit in clock cycles after reset
    localparam int    CYCLE_BUDGET = 200;
    localparam string PROG_FILE    = "program.hex";

    logic            clk;
    logic            arstN;
    logic [XLEN-1:0] a0;

    // isa model state
    logic [31:0] progMem   [IMEM_WORDS];
    logic [31:0] modelMem  [DMEM_WORDS];
    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    logic        modelHalted;

    int cycle;

    rvCore i_dut (
        .clk   (clk),
        .arstN (arstN),
        .a0    (a0)
    );

    // 20 unit period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // add/sub, slt, or, and as the isa defines them
    function automatic logic [31:0] arithResult(input logic [2:0] f3, input logic [31:0] x,
                                                input logic [31:0] y, input logic isSub);
        case (f3)
            F3_ADD:  return isSub ? x - y : x + y;
            F3_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            F3_OR:   return x | y;
            F3_AND:  return x & y;
            default: return 32'd0;
        endcase
    endfunction

    // retire one instruction on the model state
    function automatic void stepModel();
        logic [31:0] ins;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] nextPc;
        logic        wr;
        ins    = progMem[modelPc[7:2]];
        op     = ins[6:0];
        f3     = ins[14:12];
        rd     = ins[11:7];
        a      = modelRegs[ins[19:15]];
        b      = modelRegs[ins[24:20]];
        // immediates per the base isa formats
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        res    = 32'd0;
        addr   = 32'd0;
        wr     = 1'b0;
        nextPc = modelPc + 32'd4;
        case (op)
            OP_RTYPE: begin
                wr  = 1'b1;
                res = arithResult(f3, a, b, ins[30]);
            end
            // no subtract form for immediates
            OP_ITYPE: begin
                wr  = 1'b1;
                res = arithResult(f3, a, immI, 1'b0);
            end
            OP_LOAD: begin
                wr   = 1'b1;
                addr = a + immI;
                res  = modelMem[addr[7:2]];
            end
            OP_STORE: begin
                addr = a + immS;
                modelMem[addr[7:2]] = b;
            end
            OP_BRANCH: begin
                if ((f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b)) begin
                    nextPc = modelPc + immB;
                end
            end
            default: ;
        endcase
        // x0 never changes
        if (wr && rd != 5'd0) begin
            modelRegs[rd] = res;
        end
        // branch onto itself marks the end of the program
        modelHalted = (nextPc == modelPc);
        modelPc     = nextPc;
    endfunction

    // a0 against model x10
    task automatic compareA0(input int cycleNum);
        assert (a0 === modelRegs[REG_A0]) else begin
            $display("FAILED at time %0t: cycle %0d a0 = %h, expected %h",
                     $time, cycleNum, a0, modelRegs[REG_A0]);
            $display("*** TEST FAILED ***");
            $fatal(1, "a0 mismatch at cycle %0d", cycleNum);
        end
    endtask

    initial begin
        arstN       = 1'b0;
        modelPc     = 32'd0;
        modelHalted = 1'b0;
        cycle       = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            progMem[i] = 32'd0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            modelMem[i] = 32'd0;
        end
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'd0;
        end
        $readmemh(PROG_FILE, progMem);

        // a0 stays zero through reset, last check sits on the release edge
        repeat (4) begin
            @(negedge clk);
            compareA0(0);
        end
        arstN = 1'b1;

        // one retired instruction per rising edge, compared mid-cycle
        while (!modelHalted && cycle < CYCLE_BUDGET) begin
            @(posedge clk);
            stepModel();
            @(negedge clk);
            cycle++;
            compareA0(cycle);
        end

        if (modelHalted) begin
            $display("program reached its end after %0d cycles", cycle);
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("timeout: program never reached its end loop in %0d cycles",
                     CYCLE_BUDGET);
            $display("*** TEST FAILED ***");
            $fatal(1, "cycle budget exhausted");
        end
    end

endmodule

// File: program.hex
// one 32-bit rv32i instruction per line, word 0 at pc 0
// right-hand comment gives the assembly and the expected a0 after it
00700293 // addi x5, x0, 7        a0 0
FFD00313 // addi x6, x0, -3       a0 0
00628533 // add  a0, x5, x6       4
40628533 // sub  a0, x5, x6       10
0062F533 // and  a0, x5, x6       5
0062E533 // or   a0, x5, x6       ffffffff
00532533 // slt  a0, x6, x5       1
0062A533 // slt  a0, x5, x6       0
FFB00513 // addi a0, x0, -5       fffffffb
0062F513 // andi a0, x5, 6        6
0F02E513 // ori  a0, x5, 0xf0     f7
FFE32513 // slti a0, x6, -2       1
00502423 // sw   x5, 8(x0)
00602623 // sw   x6, 12(x0)
00802503 // lw   a0, 8(x0)        7
00C02503 // lw   a0, 12(x0)       fffffffd
00000513 // addi a0, x0, 0        0
00628463 // beq  x5, x6, +8       not taken
00150513 // addi a0, a0, 1        1
00528463 // beq  x5, x5, +8       taken
00150513 // addi a0, a0, 1        skipped
00529463 // bne  x5, x5, +8       not taken
00150513 // addi a0, a0, 1        2
00629463 // bne  x5, x6, +8       taken
00150513 // addi a0, a0, 1        skipped
00028013 // addi x0, x5, 0        x0 stays 0
00600533 // add  a0, x0, x6       fffffffd
00000063 // beq  x0, x0, 0        end loop

// File: list.f
common/rvPkg.sv
fetch/pcUnit.sv
fetch/instrMem.sv
decode/controlUnit.sv
decode/immExtend.sv
execute/registerFile.sv
execute/alu.sv
rtl/dataMem.sv
rtl/rvCore.sv
test/tbRvCore.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build folder"

# runs from the project root so program.hex is found
test:
	verilator --binary --timing --assert -j 0 --top-module tbRvCore -f list.f
	./obj_dir/VtbRvCore

clean:
	rm -rf obj_dir
